/* common/bram_pkg.sv */
`default_nettype none

package bram_pkg;

    // ==================================================================
    // Array geometry
    // ==================================================================

    localparam int ROW_COUNT      = 512;  // Rows in the array
    localparam int ROW_LANES      = 4;    // Lanes per row
    localparam int LANE_BITS      = 9;    // Data byte plus parity
    localparam int ROW_ADDR_BITS  = 9;    // log2 of ROW_COUNT

    // Port address, counted in port words
    // A port of L lanes packs 4/L words in one row
    localparam int PORT_ADDR_BITS = 11;

    // ==================================================================
    // Lane and row types
    // ==================================================================

    // One storage lane
    typedef struct packed {
        logic       parity;
        logic [7:0] data;
    } lane_t;

    // Full row, lane 0 in the low bits
    typedef lane_t [ROW_LANES-1:0] row_t;

    // One write enable per lane
    typedef logic [ROW_LANES-1:0] lane_mask_t;

    // ==================================================================
    // Port request
    // ==================================================================

    // One-cycle strobe, a new request may follow every cycle
    typedef struct packed {
        logic                      en;     // Request strobe
        lane_mask_t                we;     // Narrow ports use the low bits
        logic                      srst;   // Load SRVAL into the output regs
        logic                      regce;  // Second register enable
        logic [PORT_ADDR_BITS-1:0] addr;
        row_t                      wdata;  // Narrow ports use the low lanes
    } port_req_t;

    // Read result on a same-port write
    typedef enum logic {
        WRITE_FIRST,  // New lanes show up on the read
        READ_FIRST    // Old row content is returned
    } write_mode_e;

endpackage

`default_nettype wire

/* bram_array/bram_array.sv */
`default_nettype none

module bram_array (
    input  logic                               CLKA,
    input  logic [bram_pkg::ROW_ADDR_BITS-1:0] row_a,
    input  logic [bram_pkg::ROW_ADDR_BITS-1:0] row_b,
    input  bram_pkg::lane_mask_t               mask_a,
    input  bram_pkg::lane_mask_t               mask_b,
    input  bram_pkg::row_t                     wrow_a,
    input  bram_pkg::row_t                     wrow_b,
    output bram_pkg::row_t                     rrow_a,
    output bram_pkg::row_t                     rrow_b
);
    import bram_pkg::*;

    // ==================================================================
    // Storage
    // ==================================================================

    // Contents survive rst
    row_t mem [ROW_COUNT];

    // ==================================================================
    // Lane-masked writes
    // ==================================================================

    always_ff @(posedge CLKA) begin
        for (int i = 0; i < ROW_LANES; i++) begin
            if (mask_b[i]) begin
                mem[row_b][i] <= wrow_b[i];
            end
            // Issued last so port A wins a shared lane
            if (mask_a[i]) begin
                mem[row_a][i] <= wrow_a[i];
            end
        end
    end

    // ==================================================================
    // Row reads
    // ==================================================================

    // Old content until the edge that writes it
    assign rrow_a = mem[row_a];
    assign rrow_b = mem[row_b];

endmodule

`default_nettype wire

/* source/read_pipe.sv */
`default_nettype none

module read_pipe #(
    parameter type      payload_t = logic [8:0],
    parameter int       OUT_REG   = 0,
    parameter payload_t SRVAL     = '0
) (
    input  logic     CLKA,
    input  logic     rst,
    input  logic     load,
    input  logic     srst,
    input  logic     regce,
    input  payload_t din,
    output payload_t dout
);

    // ==================================================================
    // First stage, the read register
    // ==================================================================

    payload_t stage1;

    always_ff @(posedge CLKA or posedge rst) begin
        if (rst) begin
            stage1 <= '0;
        end else if (load) begin
            stage1 <= srst ? SRVAL : din;  // srst beats data
        end
    end

    // ==================================================================
    // Optional second stage
    // ==================================================================

    generate
        if (OUT_REG != 0) begin : g_out_reg
            payload_t stage2;

            // Own enable, independent of load
            always_ff @(posedge CLKA or posedge rst) begin
                if (rst) begin
                    stage2 <= '0;
                end else if (regce) begin
                    stage2 <= srst ? SRVAL : stage1;
                end
            end

            assign dout = stage2;
        end else begin : g_no_out_reg
            assign dout = stage1;  // Single-cycle latency
        end
    endgenerate

endmodule

`default_nettype wire

/* bram_port/bram_port.sv */
`default_nettype none

module bram_port #(
    parameter type                   payload_t  = bram_pkg::row_t,
    parameter int                    LANES      = 4,
    parameter bram_pkg::write_mode_e WRITE_MODE = bram_pkg::WRITE_FIRST,
    parameter int                    OUT_REG    = 0,
    parameter payload_t              SRVAL      = '0
) (
    input  logic                               CLKA,
    input  logic                               rst,
    input  bram_pkg::port_req_t                req,
    output logic [bram_pkg::ROW_ADDR_BITS-1:0] row,
    output bram_pkg::lane_mask_t               mask,
    output bram_pkg::row_t                     wrow,
    input  bram_pkg::row_t                     rrow,
    output payload_t                           dout
);
    import bram_pkg::*;

    localparam int WORDS_PER_ROW = ROW_LANES / LANES;  // Port words in one row
    localparam int LANE_SEL_BITS = $clog2(ROW_LANES);

    // ==================================================================
    // Address split
    // ==================================================================

    logic [LANE_SEL_BITS-1:0] lane_base;  // First lane of the word

    // Row is the word address over the words per row
    assign row       = ROW_ADDR_BITS'(req.addr / WORDS_PER_ROW);
    assign lane_base = LANE_SEL_BITS'((req.addr % WORDS_PER_ROW) * LANES);

    // ==================================================================
    // Write placement
    // ==================================================================

    always_comb begin
        wrow = '0;
        mask = '0;
        for (int i = 0; i < LANES; i++) begin
            wrow[int'(lane_base) + i] = req.wdata[i];
            mask[int'(lane_base) + i] = req.en & req.we[i];
        end
    end

    // ==================================================================
    // Read extraction
    // ==================================================================

    lane_t [LANES-1:0] rd_lanes;
    payload_t          rd_word;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rd_lanes[i] = rrow[int'(lane_base) + i];
            // Write-first bypass, written lanes only
            if ((WRITE_MODE == WRITE_FIRST) && mask[int'(lane_base) + i]) begin
                rd_lanes[i] = req.wdata[i];
            end
        end
    end

    assign rd_word = payload_t'(rd_lanes);

    // ==================================================================
    // Output registers
    // ==================================================================

    read_pipe #(
        .payload_t (payload_t),
        .OUT_REG   (OUT_REG),
        .SRVAL     (SRVAL)
    ) read_pipe_inst (
        .CLKA  (CLKA),
        .rst   (rst),
        .load  (req.en),     // Capture on every request
        .srst  (req.srst),
        .regce (req.regce),
        .din   (rd_word),
        .dout  (dout)
    );

    // Payload type must match the lane count of the port
    payload_fits_lanes: assert property (
        @(posedge CLKA) ($bits(payload_t) == LANES * LANE_BITS)
                        && ((LANES == 1) || (LANES == 2) || (LANES == 4))
    ) else $error("Payload of %0d bits on a %0d-lane port", $bits(payload_t), LANES);

    // Request address must name a row inside the array
    addr_in_range: assert property (
        @(posedge CLKA) disable iff (rst)
        req.en |-> ((int'(req.addr) / WORDS_PER_ROW) < ROW_COUNT)
    ) else $error("Port address %0d lies beyond the last row", req.addr);

endmodule

`default_nettype wire

/* source/dual_port_bram.sv */
`default_nettype none

module dual_port_bram #(
    parameter type                   payload_a_t  = bram_pkg::row_t,
    parameter type                   payload_b_t  = bram_pkg::lane_t [1:0],
    parameter int                    LANES_A      = 4,
    parameter int                    LANES_B      = 2,
    parameter bram_pkg::write_mode_e WRITE_MODE_A = bram_pkg::WRITE_FIRST,
    parameter bram_pkg::write_mode_e WRITE_MODE_B = bram_pkg::READ_FIRST,
    parameter int                    OUT_REG_A    = 0,
    parameter int                    OUT_REG_B    = 1,
    parameter payload_a_t            SRVAL_A      = payload_a_t'(36'h9_c3c3_c3c3),
    parameter payload_b_t            SRVAL_B      = payload_b_t'(18'h2_5a5a)
) (
    input  logic                CLKA,
    input  logic                rst,
    input  bram_pkg::port_req_t req_a,
    input  bram_pkg::port_req_t req_b,
    output payload_a_t          dout_a,
    output payload_b_t          dout_b
);
    import bram_pkg::*;

    logic [ROW_ADDR_BITS-1:0] row_a;
    logic [ROW_ADDR_BITS-1:0] row_b;
    lane_mask_t               mask_a;
    lane_mask_t               mask_b;
    row_t                     wrow_a;
    row_t                     wrow_b;
    row_t                     rrow_a;
    row_t                     rrow_b;

    // ==================================================================
    // Shared storage
    // ==================================================================

    bram_array bram_array_inst (
        .CLKA   (CLKA),
        .row_a  (row_a),
        .row_b  (row_b),
        .mask_a (mask_a),
        .mask_b (mask_b),
        .wrow_a (wrow_a),
        .wrow_b (wrow_b),
        .rrow_a (rrow_a),
        .rrow_b (rrow_b)
    );

    // ==================================================================
    // Ports
    // ==================================================================

    // Full-row port
    bram_port #(
        .payload_t  (payload_a_t),
        .LANES      (LANES_A),
        .WRITE_MODE (WRITE_MODE_A),
        .OUT_REG    (OUT_REG_A),
        .SRVAL      (SRVAL_A)
    ) port_a (
        .CLKA (CLKA),
        .rst  (rst),
        .req  (req_a),
        .row  (row_a),
        .mask (mask_a),
        .wrow (wrow_a),
        .rrow (rrow_a),
        .dout (dout_a)
    );

    // Narrow port
    bram_port #(
        .payload_t  (payload_b_t),
        .LANES      (LANES_B),
        .WRITE_MODE (WRITE_MODE_B),
        .OUT_REG    (OUT_REG_B),
        .SRVAL      (SRVAL_B)
    ) port_b (
        .CLKA (CLKA),
        .rst  (rst),
        .req  (req_b),
        .row  (row_b),
        .mask (mask_b),
        .wrow (wrow_b),
        .rrow (rrow_b),
        .dout (dout_b)
    );

endmodule

`default_nettype wire

/* tests/tb_dual_port_bram.sv */
`default_nettype none

module tb_dual_port_bram;
    import bram_pkg::*;

    localparam logic [35:0] SRVAL_A     = 36'h9_c3c3_c3c3;  // Top-level defaults
    localparam logic [17:0] SRVAL_B     = 18'h2_5a5a;
    localparam logic [31:0] SEED        = 32'h10ba_860d;
    localparam int          ROUNDS      = 8;
    localparam int          DRAIN_LIMIT = 16;

    logic        CLKA;
    logic        rst;
    port_req_t   req_a;
    port_req_t   req_b;
    row_t        dout_a;
    lane_t [1:0] dout_b;

    row_t        ref_mem [ROW_COUNT];  // Reference copy of the array
    row_t        exp_a;
    lane_t [1:0] stage_b;              // B read register
    lane_t [1:0] exp_b;
    int          idle_cycles;

    logic [31:0] lfsr;
    logic [8:0]  rows [2*ROUNDS];
    logic [35:0] wdata_r;
    logic [3:0]  we_r;
    logic        half_r;
    int          mismatches;
    int          failed_tests;
    int          test_no;
    int          mark;
    bit          timed_out;

    dual_port_bram dual_port_bram_inst (
        .CLKA   (CLKA),
        .rst    (rst),
        .req_a  (req_a),
        .req_b  (req_b),
        .dout_a (dout_a),
        .dout_b (dout_b)
    );

    initial begin
        CLKA = 1'b0;
        forever #4 CLKA = ~CLKA;
    end

    // ==================================================================
    // Reference model
    // ==================================================================

    always @(posedge CLKA or posedge rst) begin
        row_t                     cur_a;
        row_t                     cur_b;
        row_t                     new_a;
        logic [ROW_ADDR_BITS-1:0] ra;
        logic [ROW_ADDR_BITS-1:0] rb;
        int                       base_b;
        if (rst) begin
            exp_a       <= '0;
            stage_b     <= '0;
            exp_b       <= '0;
            idle_cycles <= 0;
        end else begin
            ra     = req_a.addr[8:0];
            rb     = req_b.addr[9:1];       // Two B words per row
            base_b = req_b.addr[0] ? 2 : 0;
            cur_a  = ref_mem[ra];
            cur_b  = ref_mem[rb];
            if (req_a.en) begin
                new_a = cur_a;
                for (int i = 0; i < 4; i++) begin
                    if (req_a.we[i]) begin
                        new_a[i] = req_a.wdata[i];  // A sees its own write
                    end
                end
                exp_a <= req_a.srst ? SRVAL_A : new_a;
            end
            if (req_b.en) begin
                stage_b <= req_b.srst ? SRVAL_B : {cur_b[base_b + 1], cur_b[base_b]};
            end
            if (req_b.regce) begin
                exp_b <= req_b.srst ? SRVAL_B : stage_b;
            end
            // B first, then A on top
            for (int i = 0; i < 2; i++) begin
                if (req_b.en && req_b.we[i]) begin
                    ref_mem[rb][base_b + i] = req_b.wdata[i];
                end
            end
            for (int i = 0; i < 4; i++) begin
                if (req_a.en && req_a.we[i]) begin
                    ref_mem[ra][i] = req_a.wdata[i];
                end
            end
            if (req_a.en || req_b.en) begin
                idle_cycles <= 0;
            end else if (idle_cycles < DRAIN_LIMIT) begin
                idle_cycles <= idle_cycles + 1;
            end
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    a_match: assert property (@(posedge CLKA) disable iff (rst) dout_a == exp_a)
        else begin
            mismatches++;
            $display("Mismatch at %0t: dout_a %h, expected %h",
                     $time, $sampled(dout_a), $sampled(exp_a));
        end

    b_match: assert property (@(posedge CLKA) disable iff (rst) dout_b == exp_b)
        else begin
            mismatches++;
            $display("Mismatch at %0t: dout_b %h, expected %h",
                     $time, $sampled(dout_b), $sampled(exp_b));
        end

    a_holds: assert property (@(posedge CLKA) disable iff (rst) !req_a.en |=> $stable(dout_a))
        else begin
            mismatches++;
            $display("Mismatch at %0t: dout_a changed without en", $time);
        end

    b_holds: assert property (@(posedge CLKA) disable iff (rst)
                              !req_b.regce |=> $stable(dout_b))
        else begin
            mismatches++;
            $display("Mismatch at %0t: dout_b changed with regce low", $time);
        end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [35:0] take_bits(input int n);
        logic [35:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[34:0], lfsr[31]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Every lane depends on the full row index
    function automatic row_t fill_row(input logic [8:0] r);
        return {r, ~r, r ^ 9'h0a5, r ^ 9'h15a};
    endfunction

    task automatic drive_a(input logic en, input logic [3:0] we, input logic srst,
                           input logic [8:0] row, input logic [35:0] wdata);
        req_a.en    = en;
        req_a.we    = we;
        req_a.srst  = srst;
        req_a.regce = 1'b0;  // No second register on A
        req_a.addr  = {2'b00, row};
        req_a.wdata = wdata;
    endtask

    task automatic drive_b(input logic en, input logic [1:0] we, input logic srst,
                           input logic regce, input logic [9:0] addr,
                           input logic [17:0] wdata);
        req_b.en    = en;
        req_b.we    = {2'b00, we};
        req_b.srst  = srst;
        req_b.regce = regce;
        req_b.addr  = {1'b0, addr};
        req_b.wdata = {18'h0, wdata};
    endtask

    task automatic idle_all();
        drive_a(1'b0, 4'h0, 1'b0, 9'h0, 36'h0);
        drive_b(1'b0, 2'b00, 1'b0, 1'b1, 10'h0, 18'h0);
    endtask

    task automatic next_cycle();
        @(negedge CLKA);
    endtask

    // Idle until both read pipes have emptied
    task automatic drain();
        int waited;
        waited = 0;
        idle_all();
        while ((idle_cycles < 3) && (waited < DRAIN_LIMIT)) begin
            next_cycle();
            waited++;
        end
        if (idle_cycles < 3) begin
            $display("Timeout: read pipes still busy after %0d cycles", waited);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        int delta;
        drain();
        delta   = mismatches - mark;
        test_no = test_no + 1;
        if (delta != 0) begin
            failed_tests = failed_tests + 1;
        end
        $display("Test %0d, %s: %0d mismatches, %s", test_no, name, delta,
                 (delta == 0) ? "ok" : "failed");
        mark = mismatches;
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        lfsr         = SEED;
        mismatches   = 0;
        failed_tests = 0;
        test_no      = 0;
        timed_out    = 1'b0;
        rst          = 1'b1;
        idle_all();
        repeat (2) @(negedge CLKA);
        rst = 1'b0;

        for (int r = 0; r < ROW_COUNT; r++) begin  // Fill every row through A
            drive_a(1'b1, 4'hf, 1'b0, 9'(r), fill_row(9'(r)));
            next_cycle();
        end
        drain();
        mark = mismatches;

        for (int k = 0; k < ROUNDS; k++) begin
            rows[k] = 9'(take_bits(9));
            drive_a(1'b1, 4'hf, 1'b0, rows[k], take_bits(36));
            next_cycle();
        end
        drive_a(1'b0, 4'h0, 1'b0, 9'h0, 36'h0);
        for (int k = 0; k < ROUNDS; k++) begin
            drive_b(1'b1, 2'b00, 1'b0, 1'b1, {rows[k], 1'b0}, 18'h0);  // Lanes 0 and 1
            next_cycle();
            drive_b(1'b1, 2'b00, 1'b0, 1'b1, {rows[k], 1'b1}, 18'h0);  // Lanes 2 and 3
            next_cycle();
        end
        report_test("full-row writes, half-row reads");

        for (int k = 0; k < ROUNDS; k++) begin
            rows[2*k]     = 9'(take_bits(9));
            rows[2*k + 1] = 9'(take_bits(9));
            we_r          = 4'(take_bits(4));
            wdata_r       = take_bits(36);
            drive_a(1'b1, we_r, 1'b0, rows[2*k], wdata_r);
            we_r   = 4'(take_bits(2));
            half_r = 1'(take_bits(1));
            drive_b(1'b1, we_r[1:0], 1'b0, 1'b1, {rows[2*k + 1], half_r}, 18'(take_bits(18)));
            next_cycle();
        end
        for (int k = 0; k < 2*ROUNDS; k++) begin
            drive_a(1'b1, 4'h0, 1'b0, rows[k], 36'h0);
            drive_b(1'b1, 2'b00, 1'b0, 1'b1, {rows[k], k[0]}, 18'h0);
            next_cycle();
        end
        report_test("partial lane writes");

        for (int k = 0; k < ROUNDS; k++) begin
            rows[k] = 9'(take_bits(9));
            half_r  = 1'(take_bits(1));
            wdata_r = take_bits(36);
            // Separate rows, so only the write mode decides
            drive_a(1'b1, k[0] ? 4'b0101 : 4'hf, 1'b0, rows[k], wdata_r);
            drive_b(1'b1, 2'b11, 1'b0, 1'b1, {rows[k] ^ 9'h100, half_r}, 18'(wdata_r));
            next_cycle();
            drive_a(1'b1, 4'h0, 1'b0, rows[k], 36'h0);
            drive_b(1'b1, 2'b00, 1'b0, 1'b1, {rows[k] ^ 9'h100, half_r}, 18'h0);
            next_cycle();
        end
        report_test("write-first on A, read-first on B");

        for (int k = 0; k < ROUNDS; k++) begin
            drive_a((k % 3) != 2, 4'h0, 1'b0, 9'(take_bits(9)), 36'h0);
            drive_b((k < 4) || (k > 5), 2'b00, 1'b0, k > 3, 10'(take_bits(10)), 18'h0);
            next_cycle();
        end
        report_test("second register enable");

        drive_a(1'b1, 4'h0, 1'b0, 9'(take_bits(9)), 36'h0);
        drive_b(1'b1, 2'b00, 1'b0, 1'b1, 10'(take_bits(10)), 18'h0);
        next_cycle();
        idle_all();
        next_cycle();
        next_cycle();
        rst = 1'b1;
        next_cycle();
        next_cycle();
        rst = 1'b0;
        next_cycle();  // Both outputs back at zero
        drive_a(1'b1, 4'h0, 1'b1, 9'h0, 36'h0);
        drive_b(1'b1, 2'b00, 1'b1, 1'b1, 10'h0, 18'h0);
        next_cycle();
        drive_a(1'b0, 4'h0, 1'b1, 9'h0, 36'h0);  // srst alone leaves dout_a
        drive_b(1'b1, 2'b00, 1'b0, 1'b0, 10'(take_bits(10)), 18'h0);
        next_cycle();
        drive_b(1'b0, 2'b00, 1'b1, 1'b1, 10'h0, 18'h0);  // Second register only
        next_cycle();
        drive_b(1'b0, 2'b00, 1'b0, 1'b1, 10'h0, 18'h0);
        next_cycle();
        report_test("reset and output reset values");

        for (int k = 0; k < ROUNDS; k++) begin
            rows[k] = 9'(take_bits(9));
            half_r  = 1'(take_bits(1));
            wdata_r = take_bits(36);
            drive_a(1'b1, 4'hf, 1'b0, rows[k], wdata_r);
            drive_b(1'b1, 2'b11, 1'b0, 1'b1, {rows[k], half_r}, 18'(take_bits(18)));
            next_cycle();
            drive_a(1'b1, 4'h0, 1'b0, rows[k], 36'h0);
            drive_b(1'b1, 2'b00, 1'b0, 1'b1, {rows[k], half_r}, 18'h0);
            next_cycle();
        end
        report_test("same-cycle write collision");

        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 test_no, failed_tests, mismatches);
        if (timed_out || (failed_tests != 0) || (mismatches != 0)) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/bram_pkg.sv
bram_array/bram_array.sv
source/read_pipe.sv
bram_port/bram_port.sv
source/dual_port_bram.sv
tests/tb_dual_port_bram.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_port_bram
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
